// File: filelist.f
src/dcache_pkg.sv
src/line_memory.sv
src/dcache_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/dcache_asserts.sv
testbench/dcache_tb.sv

// File: run.sh
#!/bin/sh
# Builds the data-cache testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/dcache_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f filelist.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "run.sh: no pass report found in $LOG"
    exit 1
fi

echo "run.sh: done"
exit 0

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,

    input  core_req_t        req_i,
    input  logic             hit_i,
    input  logic             victim_dirty_i,
    input  logic [TAG_W-1:0] victim_tag_i,
    input  line_t            victim_line_i,

    input  mem_rsp_t         mem_rsp_i,
    output mem_req_t         mem_req_o,

    output logic             fill_en_o,
    output logic             store_en_o,
    output logic             load_en_o,
    output logic             done_o,
    output logic             hit_o
);

    cache_state_e state_q;

    logic req_active;
    logic issue_wb;
    logic issue_rd;
    logic refill_q;
    logic done_q;
    logic hit_q;

    logic                   mem_stb_q;
    logic                   mem_we_q;
    logic [LINE_ADDR_W-1:0] mem_addr_q;
    line_t                  mem_line_q;

    // The done cycle still sees the old request, so it is skipped.
    assign req_active = (req_i.rd || req_i.wr) && !done_q;

    assign issue_wb = (state_q == TAG_CHECK) && req_active && !hit_i && victim_dirty_i;
    assign issue_rd = ((state_q == TAG_CHECK) && req_active && !hit_i && !victim_dirty_i)
                   || ((state_q == WRITEBACK) && mem_rsp_i.ack);

    // ~~~~~~~~~~~~~~~~~~~~
    // FSM.
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= TAG_CHECK;
            mem_stb_q <= 1'b0;
            mem_we_q  <= 1'b0;
            refill_q  <= 1'b0;
            done_q    <= 1'b0;
            hit_q     <= 1'b0;
        end else begin
            mem_stb_q <= issue_wb || issue_rd;
            done_q    <= 1'b0;
            hit_q     <= 1'b0;
            if (issue_wb) begin
                mem_we_q <= 1'b1;
            end else if (issue_rd) begin
                mem_we_q <= 1'b0;
            end
            case (state_q)
                TAG_CHECK: begin
                    if (req_active) begin
                        if (hit_i) begin
                            state_q <= ACCESS;
                        end else if (victim_dirty_i) begin
                            state_q  <= WRITEBACK;
                            refill_q <= 1'b1;
                        end else begin
                            state_q  <= REFILL;
                            refill_q <= 1'b1;
                        end
                    end
                end
                ACCESS: begin
                    state_q  <= TAG_CHECK;
                    done_q   <= 1'b1;
                    hit_q    <= !refill_q;
                    refill_q <= 1'b0;
                end
                WRITEBACK: begin
                    if (mem_rsp_i.ack) state_q <= REFILL;
                end
                REFILL: begin
                    if (mem_rsp_i.ack) state_q <= TAG_CHECK;
                end
                default: state_q <= TAG_CHECK;
            endcase
        end
    end

    // The memory request payload is captured with the strobe.
    always_ff @(posedge clk_i) begin
        if (issue_wb) begin
            mem_addr_q <= {victim_tag_i, req_i.addr[OFFSET_W+INDEX_W-1:OFFSET_W]};
            mem_line_q <= victim_line_i;
        end else if (issue_rd) begin
            mem_addr_q <= req_i.addr[ADDR_W-1:OFFSET_W];
        end
    end

    assign mem_req_o = '{req: mem_stb_q, we: mem_we_q, line_addr: mem_addr_q, line: mem_line_q};

    assign fill_en_o  = (state_q == REFILL) && mem_rsp_i.ack;
    assign store_en_o = (state_q == ACCESS) && req_i.wr;
    assign load_en_o  = (state_q == ACCESS) && req_i.rd;
    assign done_o     = done_q;
    assign hit_o      = hit_q;

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Geometry.
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W      = 10;
    localparam int DATA_W      = 32;
    localparam int LINE_BYTES  = 16;
    localparam int NUM_LINES   = 4;
    localparam int OFFSET_W    = $clog2(LINE_BYTES);
    localparam int INDEX_W     = $clog2(NUM_LINES);
    localparam int TAG_W       = ADDR_W - OFFSET_W - INDEX_W;
    localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

    // Main memory model.
    localparam int MEM_LINES   = 64;
    localparam int MEM_LATENCY = 4;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

    // ~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } memop_size_e;

    typedef enum logic [1:0] {
        TAG_CHECK,
        ACCESS,
        WRITEBACK,
        REFILL
    } cache_state_e;

    // Byte 0 sits in bits 7:0, so word and half views stay little endian.
    typedef logic [LINE_BYTES-1:0][7:0] line_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        memop_size_e       size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } core_req_t;

    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [LINE_ADDR_W-1:0] line_addr;
        line_t                  line;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        line_t line;
    } mem_rsp_t;

endpackage

// File: src/dcache_store.sv
`timescale 1ns/1ps

module dcache_store import dcache_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,

    input  core_req_t        req_i,
    input  logic             fill_en_i,
    input  logic             store_en_i,
    input  logic             load_en_i,
    input  line_t            fill_line_i,

    output logic             hit_o,
    output logic             victim_dirty_o,
    output logic [TAG_W-1:0] victim_tag_o,
    output line_t            victim_line_o,
    output logic [DATA_W-1:0] rdata_o
);

    logic [TAG_W-1:0]    addr_tag;
    logic [INDEX_W-1:0]  addr_index;
    logic [OFFSET_W-1:0] addr_offset;

    logic [NUM_LINES-1:0]            valid_q;
    logic [NUM_LINES-1:0]            dirty_q;
    logic [NUM_LINES-1:0][TAG_W-1:0] tag_q;
    line_t [NUM_LINES-1:0]           data_q;

    line_t                                 cur_line;
    logic [LINE_BYTES/2-1:0][15:0]         cur_halves;
    logic [LINE_BYTES/4-1:0][DATA_W-1:0]   cur_words;
    logic [DATA_W-1:0]                     load_val;
    logic [LINE_BYTES-1:0]                 wr_be;
    line_t                                 wr_line;

    assign addr_tag    = req_i.addr[ADDR_W-1:OFFSET_W+INDEX_W];
    assign addr_index  = req_i.addr[OFFSET_W+INDEX_W-1:OFFSET_W];
    assign addr_offset = req_i.addr[OFFSET_W-1:0];

    assign cur_line   = data_q[addr_index];
    assign cur_halves = cur_line;
    assign cur_words  = cur_line;

    // Lookup.
    assign hit_o          = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
    assign victim_dirty_o = valid_q[addr_index] && dirty_q[addr_index];
    assign victim_tag_o   = tag_q[addr_index];
    assign victim_line_o  = cur_line;

    // ~~~~~~~~~~~~~~~~~~~~
    // Load extraction and store lanes.
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        load_val = '0;
        wr_be    = '0;
        wr_line  = '0;
        case (req_i.size)
            SIZE_BYTE: begin
                load_val = {24'b0, cur_line[addr_offset]};
                wr_be    = LINE_BYTES'(1) << addr_offset;
                wr_line  = {LINE_BYTES{req_i.wdata[7:0]}};
            end
            SIZE_HALF: begin
                load_val = {16'b0, cur_halves[addr_offset[OFFSET_W-1:1]]};
                wr_be    = LINE_BYTES'(3) << {addr_offset[OFFSET_W-1:1], 1'b0};
                wr_line  = {(LINE_BYTES/2){req_i.wdata[15:0]}};
            end
            SIZE_WORD: begin
                load_val = cur_words[addr_offset[OFFSET_W-1:2]];
                wr_be    = LINE_BYTES'(15) << {addr_offset[OFFSET_W-1:2], 2'b00};
                wr_line  = {(LINE_BYTES/4){req_i.wdata}};
            end
            default: ;
        endcase
    end

    // Valid and dirty bits.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en_i) begin
            valid_q[addr_index] <= 1'b1;
            dirty_q[addr_index] <= 1'b0;
        end else if (store_en_i) begin
            dirty_q[addr_index] <= 1'b1;
        end
    end

    // Tags, line data and load result.
    always_ff @(posedge clk_i) begin
        if (fill_en_i) begin
            tag_q[addr_index]  <= addr_tag;
            data_q[addr_index] <= fill_line_i;
        end else if (store_en_i) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_be[b]) begin
                    data_q[addr_index][b] <= wr_line[b];
                end
            end
        end
        if (load_en_i) begin
            rdata_o <= load_val;
        end
    end

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  core_req_t         core_req_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              done_o,
    output logic              hit_o
);

    logic             store_hit;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    line_t            victim_line;
    logic             fill_en;
    logic             store_en;
    logic             load_en;
    mem_req_t         mem_req;
    mem_rsp_t         mem_rsp;

    dcache_ctrl ctrl0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (core_req_i),
        .hit_i          (store_hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_line_i  (victim_line),
        .mem_rsp_i      (mem_rsp),
        .mem_req_o      (mem_req),
        .fill_en_o      (fill_en),
        .store_en_o     (store_en),
        .load_en_o      (load_en),
        .done_o         (done_o),
        .hit_o          (hit_o)
    );

    dcache_store store0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (core_req_i),
        .fill_en_i      (fill_en),
        .store_en_i     (store_en),
        .load_en_i      (load_en),
        .fill_line_i    (mem_rsp.line),
        .hit_o          (store_hit),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_line_o  (victim_line),
        .rdata_o        (rdata_o)
    );

    line_memory mem0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

// File: src/line_memory.sv
`timescale 1ns/1ps

module line_memory import dcache_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  mem_req_t mem_req_i,
    output mem_rsp_t mem_rsp_o
);

    line_t mem_q [MEM_LINES];

    logic                   busy_q;
    logic [LAT_CNT_W-1:0]   cnt_q;
    logic                   ack_q;
    logic                   we_q;
    logic [LINE_ADDR_W-1:0] addr_q;
    line_t                  wline_q;
    line_t                  rline_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Latency counter.
    // ~~~~~~~~~~~~~~~~~~~~

    // Strobes while busy are dropped.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (!busy_q) begin
                if (mem_req_i.req) begin
                    busy_q <= 1'b1;
                    cnt_q  <= LAT_CNT_W'(MEM_LATENCY - 1);
                end
            end else if (cnt_q == LAT_CNT_W'(1)) begin
                busy_q <= 1'b0;
                ack_q  <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Request latch and array access.
    always_ff @(posedge clk_i) begin
        if (!busy_q && mem_req_i.req) begin
            we_q    <= mem_req_i.we;
            addr_q  <= mem_req_i.line_addr;
            wline_q <= mem_req_i.line;
        end
        if (busy_q && (cnt_q == LAT_CNT_W'(1))) begin
            if (we_q) mem_q[addr_q] <= wline_q;
            else      rline_q       <= mem_q[addr_q];
        end
    end

    assign mem_rsp_o = '{ack: ack_q, line: rline_q};

endmodule

// File: testbench/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts import dcache_pkg::*; (
    input logic     clk_i,
    input logic     rst_n_i,
    input logic     done_i,
    input mem_req_t mem_req_i,
    input mem_rsp_t mem_rsp_i
);

    logic pending_q;

    // Set by a memory strobe, cleared by its ack.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (mem_req_i.req) begin
            pending_q <= 1'b1;
        end else if (mem_rsp_i.ack) begin
            pending_q <= 1'b0;
        end
    end

    done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    single_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i.req |-> !pending_q)
        else $error("memory strobe issued while another request is outstanding");

    no_done_with_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(done_i && mem_req_i.req))
        else $error("done_o coincides with a memory strobe");

    // The ack pulses exactly MEM_LATENCY cycles after each strobe.
    ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_i.ack == $past(mem_req_i.req, MEM_LATENCY))
        else $error("memory ack does not follow its strobe after MEM_LATENCY cycles");

endmodule

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SEED         = 19;
    localparam int PRELOAD_REQS = (1 << ADDR_W) / 4;
    localparam int RAND_REQS    = 300;
    localparam int NUM_REQS     = PRELOAD_REQS + 4 + 48 + 3 + RAND_REQS;
    // Worst case is a dirty miss with writeback, refill, tag check, access, done and idle.
    localparam int WORST_CYCLES = 2 * (MEM_LATENCY + 1) + 5;
    localparam int TIMEOUT_NS   = (NUM_REQS * WORST_CYCLES + RESET_CYCLES + 100) * CLK_PERIOD;
    localparam logic [ADDR_W-1:0] SUB_BASE = 10'h100;

    typedef struct packed {
        logic              is_load;
        logic              hit;
        logic [DATA_W-1:0] data;
        logic              timed;
        logic [31:0]       issue_cyc;
    } expect_t;

    logic              clk;
    logic              rst_n;
    core_req_t         core_req;
    logic [DATA_W-1:0] rdata;
    logic              done;
    logic              hit;

    expect_t     exp_q [$];
    logic [31:0] cycle_cnt = '0;
    logic [31:0] lcg_state = 32'(SEED);
    int          errors = 0;
    int          checks = 0;
    int          req_count = 0;
    int          test_reqs0 = 0;
    int          test_errs0 = 0;

    // Shadow of the whole address space and of the cache tags.
    logic [7:0]           shadow_mem [1 << ADDR_W];
    logic [NUM_LINES-1:0] shadow_valid = '0;
    logic [TAG_W-1:0]     shadow_tag [NUM_LINES];

    dcache_top dut0 (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .core_req_i (core_req),
        .rdata_o    (rdata),
        .done_o     (done),
        .hit_o      (hit)
    );

    bind dcache_ctrl dcache_asserts asserts0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .done_i    (done_o),
        .mem_req_i (mem_req_o),
        .mem_rsp_i (mem_rsp_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Preload data depends on every address bit.
    function automatic logic [DATA_W-1:0] fill_pattern(input logic [ADDR_W-1:0] a);
        return {a, ~a, 12'hA5C};
    endfunction

    function automatic core_req_t make_req(input logic rd, input logic wr,
                                           input memop_size_e size,
                                           input logic [ADDR_W-1:0] addr,
                                           input logic [DATA_W-1:0] wdata);
        core_req_t r;
        r.rd    = rd;
        r.wr    = wr;
        r.size  = size;
        r.addr  = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // Predicts the hit from the shadow tags, then applies the access to the shadow.
    function automatic void reference_model(input core_req_t req,
                                            output logic [DATA_W-1:0] data,
                                            output logic exp_hit);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic [ADDR_W-1:0]  a;
        int                 nbytes;
        idx     = req.addr[OFFSET_W+INDEX_W-1:OFFSET_W];
        tag     = req.addr[ADDR_W-1:OFFSET_W+INDEX_W];
        exp_hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = tag;
        nbytes = (req.size == SIZE_BYTE) ? 1 : (req.size == SIZE_HALF) ? 2 : 4;
        data   = '0;
        for (int b = 0; b < nbytes; b++) begin
            a = req.addr + ADDR_W'(b);
            if (req.wr) begin
                shadow_mem[a] = req.wdata[8*b +: 8];
            end else begin
                data[8*b +: 8] = shadow_mem[a];
            end
        end
    endfunction

    // Drives one request on the falling edge and holds it until done_o.
    task automatic run_request(input core_req_t req, input logic timed);
        expect_t           e;
        logic [DATA_W-1:0] exp_data;
        logic              exp_hit;
        reference_model(req, exp_data, exp_hit);
        e.is_load   = req.rd;
        e.hit       = exp_hit;
        e.data      = exp_data;
        e.timed     = timed;
        e.issue_cyc = cycle_cnt;
        exp_q.push_back(e);
        req_count++;
        core_req = req;
        @(negedge clk);
        while (!done) @(negedge clk);
        core_req = '0;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        $display("Test %-16s %0d requests, %0d errors", name,
                 req_count - test_reqs0, errors - test_errs0);
        test_reqs0 = req_count;
        test_errs0 = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Response checker.
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        expect_t e;
        if (done) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR: done_o pulsed with no request outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checks++;
                assert (hit == e.hit) else begin
                    $display("MISMATCH hit_o expected %h got %h", e.hit, hit);
                    errors++;
                end
                if (e.is_load) begin
                    assert (rdata == e.data) else begin
                        $display("MISMATCH rdata_o expected %h got %h", e.data, rdata);
                        errors++;
                    end
                end
                if (e.timed) begin
                    assert (cycle_cnt - e.issue_cyc == 32'd2) else begin
                        $display("ERROR: hit took %0d cycles from request to done_o, not 2",
                                 cycle_cnt - e.issue_cyc);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: timeout after %0d ns, done_o never arrived", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] r;
        logic [1:0]        sz_bits;
        memop_size_e       size;
        logic              rd;
        core_req = '0;
        rst_n    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!done && !hit) else begin
            $display("ERROR: done_o or hit_o high after reset");
            errors++;
        end

        // Word stores over the whole space so every later load reads defined data.
        for (int a = 0; a < (1 << ADDR_W); a += 4) begin
            addr = ADDR_W'(a);
            run_request(make_req(1'b0, 1'b1, SIZE_WORD, addr, fill_pattern(addr)), 1'b0);
        end
        end_test("preload");

        // The last preloaded line is still resident.
        for (int off = 0; off < LINE_BYTES; off += 4) begin
            addr = 10'h3F0 + ADDR_W'(off);
            run_request(make_req(1'b1, 1'b0, SIZE_WORD, addr, '0), 1'b1);
        end
        end_test("hit_timing");

        for (int off = 0; off < LINE_BYTES; off++) begin
            addr = SUB_BASE + ADDR_W'(off);
            run_request(make_req(1'b0, 1'b1, SIZE_BYTE, addr, next_random()), 1'b0);
            addr[1:0] = 2'b00;
            run_request(make_req(1'b1, 1'b0, SIZE_WORD, addr, '0), 1'b0);
        end
        for (int off = 0; off < LINE_BYTES; off += 2) begin
            addr = SUB_BASE + ADDR_W'(off);
            run_request(make_req(1'b0, 1'b1, SIZE_HALF, addr, next_random()), 1'b0);
            addr[1:0] = 2'b00;
            run_request(make_req(1'b1, 1'b0, SIZE_WORD, addr, '0), 1'b0);
        end
        end_test("subword_merge");

        // A different tag on the same index forces the dirty first line out.
        run_request(make_req(1'b0, 1'b1, SIZE_WORD, 10'h040, next_random()), 1'b0);
        run_request(make_req(1'b0, 1'b1, SIZE_WORD, 10'h240, next_random()), 1'b0);
        run_request(make_req(1'b1, 1'b0, SIZE_WORD, 10'h040, '0), 1'b0);
        end_test("dirty_eviction");

        for (int i = 0; i < RAND_REQS; i++) begin
            r       = next_random();
            rd      = r[31];
            sz_bits = 2'(r[29:24] % 6'd3);
            size    = memop_size_e'(sz_bits);
            addr    = r[23:14];
            if (size == SIZE_HALF) addr[0] = 1'b0;
            if (size == SIZE_WORD) addr[1:0] = 2'b00;
            run_request(make_req(rd, !rd, size, addr, next_random()), 1'b0);
        end
        end_test("random_traffic");

        assert (exp_q.size() == 0) else begin
            $display("ERROR: %0d requests never completed", exp_q.size());
            errors++;
        end
        $display("Total: %0d requests, %0d checks, %0d errors", req_count, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
